//--- common/ooo_pkg.sv
package ooo_pkg;

    localparam int XLEN = 32;

    // reorder buffer size, must match the width of rob_idx_t
    localparam int ROB_DEPTH = 32;

    // register stages in the multiplier
    localparam int MUL_STAGES = 3;

    typedef logic [XLEN-1:0] xlen_t;
    typedef logic [31:0] pc_t;
    typedef logic [4:0] reg_addr_t;
    typedef logic [$clog2(ROB_DEPTH)-1:0] rob_idx_t;

    // one extra bit so a full buffer can be counted
    typedef logic [$clog2(ROB_DEPTH):0] rob_cnt_t;

    typedef enum logic [2:0] {
        op_add,
        op_sub,
        op_xor,
        op_beq,
        op_bne,
        op_mul
    } op_t;

    typedef enum logic [1:0] {
        rob_empty,
        rob_wait,
        rob_done
    } rob_state_t;

    // payload of one reorder buffer slot
    typedef struct packed {
        op_t       op;
        pc_t       pc;
        reg_addr_t rd;
        logic      we;
        logic      pred_taken;
        xlen_t     result;
        logic      br_taken;
        pc_t       br_target;
    } rob_entry_t;

    function automatic logic is_branch(op_t op);
        return (op == op_beq) || (op == op_bne);
    endfunction

endpackage

//--- common/cdb_if.sv
interface cdb_if;
    import ooo_pkg::*;

    logic     valid;
    rob_idx_t tag;
    xlen_t    data;
    // branch outcome, only meaningful on the alu bus
    logic     br_taken;
    pc_t      br_target;

    modport unit (
        output valid, tag, data, br_taken, br_target
    );

    modport buffer (
        input valid, tag, data, br_taken, br_target
    );

endinterface

//--- rob/rob.sv
module rob (
    input  logic               clk,
    input  logic               rst,
    input  logic               alloc_i,
    input  ooo_pkg::op_t       alloc_op_i,
    input  ooo_pkg::pc_t       alloc_pc_i,
    input  ooo_pkg::reg_addr_t alloc_rd_i,
    input  logic               alloc_pred_taken_i,
    output ooo_pkg::rob_idx_t  alloc_tag_o,
    output logic               full_o,
    cdb_if.buffer              alu_cdb,
    cdb_if.buffer              mul_cdb,
    output logic               retire_valid_o,
    output ooo_pkg::pc_t       retire_pc_o,
    output ooo_pkg::reg_addr_t retire_rd_o,
    output logic               retire_we_o,
    output ooo_pkg::xlen_t     retire_data_o,
    output logic               flush_o,
    output ooo_pkg::pc_t       redirect_pc_o
);
    import ooo_pkg::*;

    rob_state_t state_q [ROB_DEPTH];
    rob_entry_t entry_q [ROB_DEPTH];

    rob_idx_t head_q;
    rob_idx_t tail_q;
    rob_cnt_t count_q;
    logic     ready_q;

    rob_entry_t head_entry;
    logic       mispredict;

    assign head_entry = entry_q[head_q];
    assign alloc_tag_o = tail_q;

    // held full until the first cycle out of reset
    assign full_o = (count_q == rob_cnt_t'(ROB_DEPTH)) || !ready_q;

    // head retires as soon as its result is in
    assign retire_valid_o = (state_q[head_q] == rob_done);
    assign retire_pc_o = head_entry.pc;
    assign retire_rd_o = head_entry.rd;
    assign retire_we_o = retire_valid_o && head_entry.we;
    assign retire_data_o = head_entry.result;

    assign mispredict = retire_valid_o && is_branch(head_entry.op)
                        && (head_entry.br_taken != head_entry.pred_taken);
    assign flush_o = mispredict;
    assign redirect_pc_o = head_entry.br_taken ? head_entry.br_target
                                               : head_entry.pc + pc_t'(4);

    always_ff @(posedge clk) begin
        if (rst) begin
            head_q <= '0;
            tail_q <= '0;
            count_q <= '0;
            ready_q <= 1'b0;
            for (int i = 0; i < ROB_DEPTH; i++) begin
                state_q[i] <= rob_empty;
            end
        end else if (flush_o) begin
            // drop the branch and everything younger
            head_q <= head_q + rob_idx_t'(1);
            tail_q <= head_q + rob_idx_t'(1);
            count_q <= '0;
            for (int i = 0; i < ROB_DEPTH; i++) begin
                state_q[i] <= rob_empty;
            end
        end else begin
            ready_q <= 1'b1;
            if (alu_cdb.valid) begin
                state_q[alu_cdb.tag] <= rob_done;
            end
            if (mul_cdb.valid) begin
                state_q[mul_cdb.tag] <= rob_done;
            end
            if (retire_valid_o) begin
                state_q[head_q] <= rob_empty;
                head_q <= head_q + rob_idx_t'(1);
            end
            if (alloc_i) begin
                state_q[tail_q] <= rob_wait;
                tail_q <= tail_q + rob_idx_t'(1);
            end
            case ({alloc_i, retire_valid_o})
                2'b10: count_q <= count_q + rob_cnt_t'(1);
                2'b01: count_q <= count_q - rob_cnt_t'(1);
                default: count_q <= count_q;
            endcase
        end
    end

    // payload, alloc and writeback touch disjoint fields
    always_ff @(posedge clk) begin
        if (alloc_i) begin
            entry_q[tail_q].op <= alloc_op_i;
            entry_q[tail_q].pc <= alloc_pc_i;
            entry_q[tail_q].rd <= alloc_rd_i;
            entry_q[tail_q].we <= !is_branch(alloc_op_i) && (alloc_rd_i != '0);
            entry_q[tail_q].pred_taken <= alloc_pred_taken_i;
        end
        if (alu_cdb.valid) begin
            entry_q[alu_cdb.tag].result <= alu_cdb.data;
            entry_q[alu_cdb.tag].br_taken <= alu_cdb.br_taken;
            entry_q[alu_cdb.tag].br_target <= alu_cdb.br_target;
        end
        if (mul_cdb.valid) begin
            entry_q[mul_cdb.tag].result <= mul_cdb.data;
            entry_q[mul_cdb.tag].br_taken <= mul_cdb.br_taken;
            entry_q[mul_cdb.tag].br_target <= mul_cdb.br_target;
        end
    end

    // dispatch steering in the top level must respect full
    a_no_alloc_full: assert property (@(posedge clk) disable iff (rst)
        alloc_i |-> !full_o);

    // units must only write back live, unfinished entries
    a_alu_wb_wait: assert property (@(posedge clk) disable iff (rst)
        alu_cdb.valid |-> (state_q[alu_cdb.tag] == rob_wait));

    a_mul_wb_wait: assert property (@(posedge clk) disable iff (rst)
        mul_cdb.valid |-> (state_q[mul_cdb.tag] == rob_wait));

    a_count_bound: assert property (@(posedge clk) disable iff (rst)
        count_q <= rob_cnt_t'(ROB_DEPTH));

endmodule

//--- src/alu_pipe.sv
module alu_pipe (
    input  logic              clk,
    input  logic              rst,
    input  logic              issue_i,
    input  ooo_pkg::op_t      op_i,
    input  ooo_pkg::pc_t      pc_i,
    input  ooo_pkg::xlen_t    a_i,
    input  ooo_pkg::xlen_t    b_i,
    input  ooo_pkg::xlen_t    imm_i,
    input  ooo_pkg::rob_idx_t tag_i,
    input  logic              flush_i,
    cdb_if.unit               cdb
);
    import ooo_pkg::*;

    xlen_t    result;
    logic     taken;
    logic     valid_q;
    rob_idx_t tag_q;
    xlen_t    data_q;
    logic     taken_q;
    pc_t      target_q;

    always_comb begin
        result = '0;
        taken = 1'b0;
        case (op_i)
            op_add: result = a_i + b_i;
            op_sub: result = a_i - b_i;
            op_xor: result = a_i ^ b_i;
            op_beq: taken = (a_i == b_i);
            op_bne: taken = (a_i != b_i);
            default: result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= issue_i;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_i) begin
            tag_q <= tag_i;
            data_q <= result;
            taken_q <= taken;
            target_q <= pc_i + imm_i;
        end
    end

    assign cdb.valid = valid_q;
    assign cdb.tag = tag_q;
    assign cdb.data = data_q;
    assign cdb.br_taken = taken_q;
    assign cdb.br_target = target_q;

endmodule

//--- src/mul_pipe.sv
module mul_pipe (
    input  logic              clk,
    input  logic              rst,
    input  logic              issue_i,
    input  ooo_pkg::xlen_t    a_i,
    input  ooo_pkg::xlen_t    b_i,
    input  ooo_pkg::rob_idx_t tag_i,
    input  logic              flush_i,
    cdb_if.unit               cdb
);
    import ooo_pkg::*;

    logic     valid_q [MUL_STAGES];
    rob_idx_t tag_q [MUL_STAGES];
    xlen_t    a_q;
    xlen_t    b_q;
    // product starts in stage 1, stage 0 only holds operands
    xlen_t    prod_q [1:MUL_STAGES-1];

    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            for (int i = 0; i < MUL_STAGES; i++) begin
                valid_q[i] <= 1'b0;
            end
        end else begin
            valid_q[0] <= issue_i;
            for (int i = 1; i < MUL_STAGES; i++) begin
                valid_q[i] <= valid_q[i-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        tag_q[0] <= tag_i;
        a_q <= a_i;
        b_q <= b_i;
        prod_q[1] <= a_q * b_q;
        for (int i = 1; i < MUL_STAGES; i++) begin
            tag_q[i] <= tag_q[i-1];
        end
        for (int i = 2; i < MUL_STAGES; i++) begin
            prod_q[i] <= prod_q[i-1];
        end
    end

    assign cdb.valid = valid_q[MUL_STAGES-1];
    assign cdb.tag = tag_q[MUL_STAGES-1];
    assign cdb.data = prod_q[MUL_STAGES-1];
    assign cdb.br_taken = 1'b0;
    assign cdb.br_target = '0;

    // a tag is reissued only after the rob frees it, far later than the pipe depth
    a_tag_unique: assert property (@(posedge clk) disable iff (rst)
        !(valid_q[0] && valid_q[1] && tag_q[0] == tag_q[1])
        && !(valid_q[0] && valid_q[2] && tag_q[0] == tag_q[2])
        && !(valid_q[1] && valid_q[2] && tag_q[1] == tag_q[2]));

endmodule

//--- src/arch_regfile.sv
module arch_regfile (
    input  logic               clk,
    input  logic               rst,
    input  logic               we_i,
    input  ooo_pkg::reg_addr_t waddr_i,
    input  ooo_pkg::xlen_t     wdata_i,
    input  ooo_pkg::reg_addr_t raddr_i,
    output ooo_pkg::xlen_t     rdata_o
);
    import ooo_pkg::*;

    // x0 has no storage
    xlen_t regs_q [1:31];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < 32; i++) begin
                regs_q[i] <= '0;
            end
        end else if (we_i && waddr_i != '0) begin
            regs_q[waddr_i] <= wdata_i;
        end
    end

    assign rdata_o = (raddr_i == '0) ? '0 : regs_q[raddr_i];

endmodule

//--- src/ooo_backend.sv
module ooo_backend (
    input  logic               clk,
    input  logic               rst,
    input  logic               disp_valid_i,
    input  ooo_pkg::op_t       disp_op_i,
    input  ooo_pkg::pc_t       disp_pc_i,
    input  ooo_pkg::reg_addr_t disp_rd_i,
    input  ooo_pkg::xlen_t     disp_rs1_val_i,
    input  ooo_pkg::xlen_t     disp_rs2_val_i,
    input  ooo_pkg::xlen_t     disp_imm_i,
    input  logic               disp_pred_taken_i,
    output logic               disp_ready_o,
    output logic               retire_valid_o,
    output ooo_pkg::pc_t       retire_pc_o,
    output ooo_pkg::reg_addr_t retire_rd_o,
    output logic               retire_we_o,
    output ooo_pkg::xlen_t     retire_data_o,
    output logic               redirect_valid_o,
    output ooo_pkg::pc_t       redirect_pc_o,
    input  ooo_pkg::reg_addr_t dbg_raddr_i,
    output ooo_pkg::xlen_t     dbg_rdata_o
);
    import ooo_pkg::*;

    logic     alloc;
    logic     full;
    logic     flush;
    logic     is_mul;
    rob_idx_t alloc_tag;

    cdb_if alu_cdb ();
    cdb_if mul_cdb ();

    // no new work while the rob is full or being flushed
    assign disp_ready_o = !full && !flush;
    assign alloc = disp_valid_i && disp_ready_o;
    assign is_mul = (disp_op_i == op_mul);
    assign redirect_valid_o = flush;

    rob u_rob (
        .clk(clk), .rst(rst),
        .alloc_i(alloc), .alloc_op_i(disp_op_i), .alloc_pc_i(disp_pc_i),
        .alloc_rd_i(disp_rd_i), .alloc_pred_taken_i(disp_pred_taken_i),
        .alloc_tag_o(alloc_tag), .full_o(full),
        .alu_cdb(alu_cdb.buffer), .mul_cdb(mul_cdb.buffer),
        .retire_valid_o(retire_valid_o), .retire_pc_o(retire_pc_o),
        .retire_rd_o(retire_rd_o), .retire_we_o(retire_we_o),
        .retire_data_o(retire_data_o),
        .flush_o(flush), .redirect_pc_o(redirect_pc_o)
    );

    alu_pipe u_alu (
        .clk(clk), .rst(rst),
        .issue_i(alloc && !is_mul), .op_i(disp_op_i), .pc_i(disp_pc_i),
        .a_i(disp_rs1_val_i), .b_i(disp_rs2_val_i), .imm_i(disp_imm_i),
        .tag_i(alloc_tag), .flush_i(flush), .cdb(alu_cdb.unit)
    );

    mul_pipe u_mul (
        .clk(clk), .rst(rst),
        .issue_i(alloc && is_mul), .a_i(disp_rs1_val_i), .b_i(disp_rs2_val_i),
        .tag_i(alloc_tag), .flush_i(flush), .cdb(mul_cdb.unit)
    );

    arch_regfile u_regfile (
        .clk(clk), .rst(rst),
        .we_i(retire_we_o), .waddr_i(retire_rd_o), .wdata_i(retire_data_o),
        .raddr_i(dbg_raddr_i), .rdata_o(dbg_rdata_o)
    );

endmodule

//--- tests/tb_ooo_backend.sv
module tb_ooo_backend;
    timeunit 1ns;
    timeprecision 100ps;
    import ooo_pkg::*;

    localparam int STALL_LIMIT = 20;
    localparam int DRAIN_LIMIT = 200;

    // one instruction as presented at the dispatch port
    typedef struct packed {
        op_t       op;
        pc_t       pc;
        reg_addr_t rd;
        xlen_t     a;
        xlen_t     b;
        xlen_t     imm;
        logic      pred;
    } instr_t;

    // what the retire and redirect ports must show for it
    typedef struct packed {
        pc_t       pc;
        reg_addr_t rd;
        logic      we;
        logic      is_br;
        xlen_t     data;
        logic      mispred;
        pc_t       redir_pc;
    } expect_t;

    logic      clk = 1'b0;
    logic      rst;
    logic      disp_valid_i;
    op_t       disp_op_i;
    pc_t       disp_pc_i;
    reg_addr_t disp_rd_i;
    xlen_t     disp_rs1_val_i;
    xlen_t     disp_rs2_val_i;
    xlen_t     disp_imm_i;
    logic      disp_pred_taken_i;
    logic      disp_ready_o;
    logic      retire_valid_o;
    pc_t       retire_pc_o;
    reg_addr_t retire_rd_o;
    logic      retire_we_o;
    xlen_t     retire_data_o;
    logic      redirect_valid_o;
    pc_t       redirect_pc_o;
    reg_addr_t dbg_raddr_i;
    xlen_t     dbg_rdata_o;

    integer  seed = 32'h872;
    expect_t model_q [$];
    xlen_t   model_regs [32];
    instr_t  port_instr;
    pc_t     next_pc;
    logic    flushing;
    int      idle_cycles;
    int      n_retired;
    int      n_mispred;
    int      n_good_br;

    ooo_backend DUT (.*);

    always #2 clk = ~clk;

    function automatic xlen_t rand_word();
        return $random(seed);
    endfunction

    task automatic report_failure(input string why);
        $display("%s", why);
        $display("FAIL: see errors above");
        $fatal(1, "simulation stopped at first failure");
    endtask

    task automatic check_value(input string name, input xlen_t got, input xlen_t expected);
        if (got !== expected) begin
            report_failure($sformatf("** Error at %0d ns: %s = 0x%h, expected 0x%h",
                                     $time, name, got, expected));
        end
    endtask

    // nothing may retire or redirect while the machine is idle
    task automatic check_quiet();
        check_value("retire_valid_o", 32'(retire_valid_o), 32'd0);
        check_value("redirect_valid_o", 32'(redirect_valid_o), 32'd0);
    endtask

    function automatic expect_t make_expect(input instr_t in);
        expect_t e;
        logic    taken;
        taken = 1'b0;
        e.data = '0;
        case (in.op)
            op_add: e.data = in.a + in.b;
            op_sub: e.data = in.a - in.b;
            op_xor: e.data = in.a ^ in.b;
            op_mul: e.data = in.a * in.b;
            op_beq: taken = (in.a == in.b);
            default: taken = (in.a != in.b);
        endcase
        e.pc = in.pc;
        e.rd = in.rd;
        e.is_br = (in.op == op_beq) || (in.op == op_bne);
        e.we = !e.is_br && (in.rd != 5'd0);
        e.mispred = e.is_br && (taken != in.pred);
        e.redir_pc = taken ? in.pc + in.imm : in.pc + 32'd4;
        return e;
    endfunction

    task automatic drive_new_instr(input logic mul_only);
        xlen_t  pick;
        instr_t in;
        pick = rand_word();
        in.a = rand_word();
        in.b = rand_word();
        in.imm = {{20{pick[15]}}, pick[15:5], 1'b0};
        in.rd = pick[20:16];
        in.pred = pick[21];
        in.pc = next_pc;
        case (pick[3:0])
            4'd0, 4'd1, 4'd2, 4'd3: in.op = op_mul;
            4'd4, 4'd5, 4'd6: in.op = op_add;
            4'd7, 4'd8, 4'd9: in.op = op_sub;
            4'd10, 4'd11, 4'd12: in.op = op_xor;
            4'd13: in.op = op_beq;
            default: in.op = op_bne;
        endcase
        if (mul_only) begin
            in.op = op_mul;
        end
        // equal operands half the time so both branch outcomes show up
        if (pick[4] && (in.op == op_beq || in.op == op_bne)) begin
            in.b = in.a;
        end
        next_pc = next_pc + 32'd4;
        port_instr = in;
        disp_valid_i <= 1'b1;
        disp_op_i <= in.op;
        disp_pc_i <= in.pc;
        disp_rd_i <= in.rd;
        disp_rs1_val_i <= in.a;
        disp_rs2_val_i <= in.b;
        disp_imm_i <= in.imm;
        disp_pred_taken_i <= in.pred;
    endtask

    task automatic check_retire();
        expect_t e;
        flushing = 1'b0;
        if (!retire_valid_o) begin
            check_value("redirect_valid_o", 32'(redirect_valid_o), 32'd0);
            if (model_q.size() != 0) begin
                idle_cycles++;
            end
            if (idle_cycles > STALL_LIMIT) begin
                report_failure("timeout: no retirement while instructions are outstanding");
            end
            return;
        end
        if (model_q.size() == 0) begin
            report_failure("retire_valid_o is high with no instruction outstanding");
        end
        e = model_q.pop_front();
        idle_cycles = 0;
        n_retired++;
        check_value("retire_pc_o", retire_pc_o, e.pc);
        check_value("retire_rd_o", 32'(retire_rd_o), 32'(e.rd));
        check_value("retire_we_o", 32'(retire_we_o), 32'(e.we));
        if (!e.is_br) begin
            check_value("retire_data_o", retire_data_o, e.data);
        end
        check_value("redirect_valid_o", 32'(redirect_valid_o), 32'(e.mispred));
        if (e.we) begin
            model_regs[e.rd] = e.data;
        end
        if (e.mispred) begin
            check_value("redirect_pc_o", redirect_pc_o, e.redir_pc);
            flushing = 1'b1;
            n_mispred++;
            // everything younger than the branch is squashed
            model_q.delete();
        end else if (e.is_br) begin
            n_good_br++;
        end
    endtask

    // sample mid cycle, then act on the next rising edge
    task automatic run_cycle(input logic want_valid, input logic mul_only);
        int   outstanding;
        logic accepted;
        @(negedge clk);
        outstanding = model_q.size();
        check_retire();
        check_value("disp_ready_o", 32'(disp_ready_o),
                    32'((outstanding < ROB_DEPTH) && !flushing));
        accepted = disp_valid_i && disp_ready_o;
        @(posedge clk);
        if (accepted) begin
            model_q.push_back(make_expect(port_instr));
        end
        // a refused instruction stays at the port
        if (accepted || !disp_valid_i) begin
            if (want_valid) begin
                drive_new_instr(mul_only);
            end else begin
                disp_valid_i <= 1'b0;
            end
        end
    endtask

    task automatic run_mixed(input int cycles);
        xlen_t w;
        repeat (cycles) begin
            w = rand_word();
            run_cycle(w[2:0] != 3'd0, 1'b0);
        end
    endtask

    task automatic drain_pipeline();
        int waited;
        waited = 0;
        while ((model_q.size() != 0 || disp_valid_i) && waited < DRAIN_LIMIT) begin
            run_cycle(1'b0, 1'b0);
            waited++;
        end
        if (model_q.size() != 0 || disp_valid_i) begin
            report_failure("timeout: instructions still outstanding after the drain");
        end
    endtask

    task automatic check_registers();
        for (int r = 0; r < 32; r++) begin
            @(posedge clk);
            dbg_raddr_i <= 5'(r);
            @(negedge clk);
            check_value($sformatf("dbg_rdata_o x%0d", r), dbg_rdata_o, model_regs[r]);
        end
    endtask

    initial begin
        int waited;
        rst = 1'b1;
        disp_valid_i = 1'b0;
        disp_op_i = op_add;
        disp_pc_i = '0;
        disp_rd_i = '0;
        disp_rs1_val_i = '0;
        disp_rs2_val_i = '0;
        disp_imm_i = '0;
        disp_pred_taken_i = 1'b0;
        dbg_raddr_i = '0;
        next_pc = 32'h0000_1000;
        port_instr = '0;
        flushing = 1'b0;
        idle_cycles = 0;
        n_retired = 0;
        n_mispred = 0;
        n_good_br = 0;
        for (int r = 0; r < 32; r++) begin
            model_regs[r] = '0;
        end

        repeat (16) begin
            @(negedge clk);
            check_value("disp_ready_o", 32'(disp_ready_o), 32'd0);
            check_quiet();
        end
        @(posedge clk);
        rst <= 1'b0;
        waited = 0;
        @(negedge clk);
        while (!disp_ready_o && waited < 8) begin
            check_quiet();
            @(negedge clk);
            waited++;
        end
        if (!disp_ready_o) begin
            report_failure("timeout: disp_ready_o never rose after reset");
        end

        // idle before the first dispatch
        repeat (8) run_cycle(1'b0, 1'b0);
        run_mixed(800);
        // back to back multiplies keep the rob busy
        repeat (300) run_cycle(1'b1, 1'b1);
        run_mixed(400);
        drain_pipeline();
        check_registers();

        $display("retired %0d, mispredicted %0d, correct branches %0d",
                 n_retired, n_mispred, n_good_br);
        if (n_mispred == 0 || n_good_br == 0) begin
            report_failure("the run did not cover both mispredicted and correct branches");
        end else begin
            $display("PASS: all tests");
            $finish;
        end
    end

endmodule

//--- list.f
common/ooo_pkg.sv
common/cdb_if.sv
rob/rob.sv
src/alu_pipe.sv
src/mul_pipe.sv
src/arch_regfile.sv
src/ooo_backend.sv
tests/tb_ooo_backend.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_ooo_backend
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
